/* dma_defs.svh */
// Width, lane and depth constants of the DMA fill pipeline, included wherever they are needed
`ifndef DMA_DEFS_SVH
`define DMA_DEFS_SVH

// Data word and DRAM address widths
`define DMA_DBW 8
`define DMA_GBW 16

// Lanes per SRAM vector, also words per DRAM beat
`define DMA_VSIZE 4

// Entries in each configuration table
`define DMA_N_ICFG 4

// SRAM row address, bounds a chunk to 16 rows
`define DMA_HBW 4

// Queue depths
`define DMA_CMDQ_DEPTH 2
`define DMA_ROWQ_DEPTH 4

`endif

/* hdl/dma_cfg_pkg.sv */
// Configuration and data types of the DMA fill pipeline, imported by RTL and testbench
`default_nettype none

`include "dma_defs.svh"

package dma_cfg_pkg;

	// ==============================
	// Data path
	// ==============================
	typedef logic [`DMA_DBW-1:0] data_t;
	typedef data_t [`DMA_VSIZE-1:0] vec_t;
	typedef logic [`DMA_GBW-1:0] addr_t;

	// ==============================
	// Table and SRAM indexing
	// ==============================
	typedef logic [$clog2(`DMA_N_ICFG)-1:0] cfg_id_t;
	typedef logic [`DMA_HBW-1:0] hiaddr_t;
	// Lane index, doubles as the bank XOR mask
	typedef logic [$clog2(`DMA_VSIZE)-1:0] lane_t;
	// Row count of a chunk, one bit wider so a full 16-row chunk fits
	typedef logic [`DMA_HBW:0] rowcnt_t;

endpackage

`default_nettype wire

/* hdl/dma_cmd_pkg.sv */
// Command types passed between the DMA pipeline stages, imported by RTL and testbench
`default_nettype none

package dma_cmd_pkg;

	import dma_cfg_pkg::*;

	// One chunk as resolved by the head
	typedef struct packed {
		logic    which;
		addr_t   base;
		addr_t   stride;
		rowcnt_t count;
		// Rows at or past this index are padding
		rowcnt_t pad_row;
		data_t   pad_value;
		lane_t   xor_mask;
	} chunk_cmd_t;

	// One SRAM row write as issued by the looper
	typedef struct packed {
		logic    which;
		hiaddr_t hiaddr;
		logic    pad;
		data_t   pad_value;
		lane_t   xor_mask;
	} row_cmd_t;

endpackage

`default_nettype wire

/* hdl/dma_queue.sv */
// Circular FIFO with rdy/ack on both sides and a payload type chosen by each instance
`default_nettype none

module dma_queue #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 2
) (
	input  wire      i_clk,
	input  wire      i_rst_n,
	input  wire      i_push_rdy,
	output logic     o_push_ack,
	input  wire payload_t i_push_data,
	output logic     o_pop_rdy,
	input  wire      i_pop_ack,
	output payload_t o_pop_data
);

	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	payload_t      mem [DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic          full;
	logic          push;
	logic          pop;

	function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] p);
		return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full       = (count == CW'(DEPTH));
	assign o_push_ack = i_push_rdy && !full;
	assign o_pop_rdy  = (count != '0);
	assign o_pop_data = mem[rd_ptr];
	assign push       = o_push_ack;
	assign pop        = o_pop_rdy && i_pop_ack;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) wr_ptr <= ptr_next(wr_ptr);
			if (pop) rd_ptr <= ptr_next(rd_ptr);
			if (push && !pop) count <= count + 1'b1;
			else if (pop && !push) count <= count - 1'b1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (push) mem[wr_ptr] <= i_push_data;
	end

	// The consumer only acks an entry that is there
	a_no_pop_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_pop_ack |-> o_pop_rdy);
	// Head entry stays put until it is taken
	a_pop_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_pop_rdy && !i_pop_ack |=> o_pop_rdy && $stable(o_pop_data));

endmodule

`default_nettype wire

/* hdl/dma_chunk_head.sv */
// Input side of the DMA pipeline that resolves each chunk from its table and queues it
`default_nettype none

`include "dma_defs.svh"

module dma_chunk_head
	import dma_cfg_pkg::*, dma_cmd_pkg::*;
(
	input  wire          i_clk,
	input  wire          i_rst_n,
	input  wire          i_bofs_rdy,
	output logic         o_bofs_ack,
	input  wire          i_which,
	input  wire addr_t   i_row_ofs,
	input  wire addr_t   i_col_ofs,
	input  wire cfg_id_t i_cfg_id,
	input  wire addr_t   i_cfg0_linears     [`DMA_N_ICFG],
	input  wire addr_t   i_cfg0_row_strides [`DMA_N_ICFG],
	input  wire rowcnt_t i_cfg0_row_counts  [`DMA_N_ICFG],
	input  wire addr_t   i_cfg0_row_bounds  [`DMA_N_ICFG],
	input  wire data_t   i_cfg0_pad_values  [`DMA_N_ICFG],
	input  wire lane_t   i_cfg0_xor_masks   [`DMA_N_ICFG],
	input  wire addr_t   i_cfg1_linears     [`DMA_N_ICFG],
	input  wire addr_t   i_cfg1_row_strides [`DMA_N_ICFG],
	input  wire rowcnt_t i_cfg1_row_counts  [`DMA_N_ICFG],
	input  wire addr_t   i_cfg1_row_bounds  [`DMA_N_ICFG],
	input  wire data_t   i_cfg1_pad_values  [`DMA_N_ICFG],
	input  wire lane_t   i_cfg1_xor_masks   [`DMA_N_ICFG],
	input  wire          i_rp_en0_rdy,
	input  wire          i_rp_en1_rdy,
	output logic         o_rp_en0_ack,
	output logic         o_rp_en1_ack,
	output logic         o_cmd_rdy,
	input  wire          i_cmd_ack,
	output chunk_cmd_t   o_cmd
);

	addr_t      sel_linear;
	addr_t      sel_stride;
	addr_t      sel_bound;
	rowcnt_t    sel_count;
	data_t      sel_pad;
	lane_t      sel_mask;
	addr_t      row_span;
	chunk_cmd_t new_cmd;
	logic       push_rdy;
	logic       push_ack;

	// ==============================
	// Table lookup
	// ==============================
	always_comb begin
		if (i_which) begin
			sel_linear = i_cfg1_linears[i_cfg_id];
			sel_stride = i_cfg1_row_strides[i_cfg_id];
			sel_bound  = i_cfg1_row_bounds[i_cfg_id];
			sel_count  = i_cfg1_row_counts[i_cfg_id];
			sel_pad    = i_cfg1_pad_values[i_cfg_id];
			sel_mask   = i_cfg1_xor_masks[i_cfg_id];
		end else begin
			sel_linear = i_cfg0_linears[i_cfg_id];
			sel_stride = i_cfg0_row_strides[i_cfg_id];
			sel_bound  = i_cfg0_row_bounds[i_cfg_id];
			sel_count  = i_cfg0_row_counts[i_cfg_id];
			sel_pad    = i_cfg0_pad_values[i_cfg_id];
			sel_mask   = i_cfg0_xor_masks[i_cfg_id];
		end
	end

	// ==============================
	// Chunk resolve
	// ==============================
	always_comb begin
		row_span          = sel_bound - i_row_ofs;
		new_cmd.which     = i_which;
		new_cmd.base      = sel_linear + i_row_ofs * sel_stride + i_col_ofs;
		new_cmd.stride    = sel_stride;
		new_cmd.count     = sel_count;
		new_cmd.pad_value = sel_pad;
		new_cmd.xor_mask  = sel_mask;
		// Rows left before the boundary floored at zero and capped at the count
		if (sel_bound <= i_row_ofs) new_cmd.pad_row = '0;
		else if (row_span >= addr_t'(sel_count)) new_cmd.pad_row = sel_count;
		else new_cmd.pad_row = rowcnt_t'(row_span);
	end

	// Only forward while the target read pipeline asks for data
	assign push_rdy     = i_bofs_rdy && (i_which ? i_rp_en1_rdy : i_rp_en0_rdy);
	assign o_bofs_ack   = push_ack;
	assign o_rp_en0_ack = push_ack && !i_which;
	assign o_rp_en1_ack = push_ack && i_which;

	dma_queue #(
		.payload_t(chunk_cmd_t),
		.DEPTH    (`DMA_CMDQ_DEPTH)
	) u_cmd_queue (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_push_rdy (push_rdy),
		.o_push_ack (push_ack),
		.i_push_data(new_cmd),
		.o_pop_rdy  (o_cmd_rdy),
		.i_pop_ack  (i_cmd_ack),
		.o_pop_data (o_cmd)
	);

	// A waiting command keeps its request and its fields
	a_bofs_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_bofs_rdy && !o_bofs_ack |=> i_bofs_rdy &&
		$stable({i_which, i_row_ofs, i_col_ofs, i_cfg_id}));

endmodule

`default_nettype wire

/* hdl/dma_row_looper.sv */
// Processing stage of the DMA pipeline, walks chunk rows into DRAM reads and row commands
`default_nettype none

module dma_row_looper
	import dma_cfg_pkg::*, dma_cmd_pkg::*;
(
	input  wire             i_clk,
	input  wire             i_rst_n,
	input  wire             i_cmd_rdy,
	output logic            o_cmd_ack,
	input  wire chunk_cmd_t i_cmd,
	output logic            o_dramra_rdy,
	input  wire             i_dramra_ack,
	output addr_t           o_dramra,
	output logic            o_row_rdy,
	input  wire             i_row_ack,
	output row_cmd_t        o_row
);

	chunk_cmd_t cur;
	addr_t      row_addr;
	rowcnt_t    row;
	logic       busy;
	// DRAM already took this row's address, row command still waiting
	logic       dram_done;
	logic       is_pad;
	logic       last;
	logic       advance;

	assign is_pad  = (row >= cur.pad_row);
	assign last    = (rowcnt_t'(row + 1'b1) == cur.count);

	// ==============================
	// Handshakes
	// ==============================
	assign o_cmd_ack    = i_cmd_rdy && !busy;
	assign o_dramra_rdy = busy && !is_pad && !dram_done;
	assign o_dramra     = row_addr;
	// A data row is pushed with its address ack or right after it
	assign o_row_rdy    = busy && (is_pad || dram_done || i_dramra_ack);
	assign advance      = o_row_rdy && i_row_ack;

	always_comb begin
		o_row.which     = cur.which;
		o_row.hiaddr    = hiaddr_t'(row);
		o_row.pad       = is_pad;
		o_row.pad_value = cur.pad_value;
		o_row.xor_mask  = cur.xor_mask;
	end

	// ==============================
	// Row walk
	// ==============================
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			busy      <= 1'b0;
			dram_done <= 1'b0;
			row       <= '0;
		end else begin
			if (o_cmd_ack) begin
				busy <= (i_cmd.count != '0);
				row  <= '0;
			end else if (advance) begin
				row <= row + 1'b1;
				if (last) busy <= 1'b0;
			end
			if (advance) dram_done <= 1'b0;
			else if (o_dramra_rdy && i_dramra_ack) dram_done <= 1'b1;
		end
	end

	// Address steps by one stride per row
	always_ff @(posedge i_clk) begin
		if (o_cmd_ack) begin
			cur      <= i_cmd;
			row_addr <= i_cmd.base;
		end else if (advance) begin
			row_addr <= row_addr + cur.stride;
		end
	end

	a_dramra_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_dramra_rdy && !i_dramra_ack |=> o_dramra_rdy && $stable(o_dramra));

endmodule

`default_nettype wire

/* hdl/dma_sram_writer.sv */
// Output side of the DMA pipeline that merges row commands with DRAM data into SRAM writes
`default_nettype none

`include "dma_defs.svh"

module dma_sram_writer
	import dma_cfg_pkg::*, dma_cmd_pkg::*;
(
	input  wire           i_clk,
	input  wire           i_rst_n,
	input  wire           i_row_rdy,
	output logic          o_row_ack,
	input  wire row_cmd_t i_row,
	input  wire           i_dramrd_rdy,
	output logic          o_dramrd_ack,
	input  wire vec_t     i_dramrd,
	output logic          o_rmc_write0_dval,
	output logic          o_rmc_write1_dval,
	output hiaddr_t       o_rmc_whiaddr,
	output vec_t          o_rmc_wdata
);

	logic     q_rdy;
	row_cmd_t q_row;
	logic     fire;
	vec_t     src;
	vec_t     scr;

	// Row queue absorbs the DRAM latency
	dma_queue #(
		.payload_t(row_cmd_t),
		.DEPTH    (`DMA_ROWQ_DEPTH)
	) u_row_queue (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_push_rdy (i_row_rdy),
		.o_push_ack (o_row_ack),
		.i_push_data(i_row),
		.o_pop_rdy  (q_rdy),
		.i_pop_ack  (fire),
		.o_pop_data (q_row)
	);

	// ==============================
	// Pairing
	// ==============================
	// Pad rows go out alone while data rows wait for their beat
	assign fire         = q_rdy && (q_row.pad || i_dramrd_rdy);
	assign o_dramrd_ack = q_rdy && !q_row.pad && i_dramrd_rdy;

	// ==============================
	// Lane scramble
	// ==============================
	always_comb begin
		if (q_row.pad) src = {`DMA_VSIZE{q_row.pad_value}};
		else src = i_dramrd;
		for (int k = 0; k < `DMA_VSIZE; k++) begin
			scr[k] = src[lane_t'(k) ^ q_row.xor_mask];
		end
	end

	// ==============================
	// SRAM write
	// ==============================
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_rmc_write0_dval <= 1'b0;
			o_rmc_write1_dval <= 1'b0;
		end else begin
			o_rmc_write0_dval <= fire && !q_row.which;
			o_rmc_write1_dval <= fire && q_row.which;
		end
	end

	always_ff @(posedge i_clk) begin
		if (fire) begin
			o_rmc_whiaddr <= q_row.hiaddr;
			o_rmc_wdata   <= scr;
		end
	end

	// DRAM holds its beat until the writer takes it
	a_dramrd_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_dramrd_rdy && !o_dramrd_ack |=> i_dramrd_rdy && $stable(i_dramrd));

endmodule

`default_nettype wire

/* hdl/dma_pipeline.sv */
// Top of the DMA fill pipeline, wires head, looper and writer to the external ports
`default_nettype none

`include "dma_defs.svh"

module dma_pipeline
	import dma_cfg_pkg::*, dma_cmd_pkg::*;
(
	input  wire          i_clk,
	input  wire          i_rst_n,
	// Chunk command
	input  wire          i_bofs_rdy,
	output logic         o_bofs_ack,
	input  wire          i_which,
	input  wire addr_t   i_row_ofs,
	input  wire addr_t   i_col_ofs,
	input  wire cfg_id_t i_cfg_id,
	// Configuration tables
	input  wire addr_t   i_cfg0_linears     [`DMA_N_ICFG],
	input  wire addr_t   i_cfg0_row_strides [`DMA_N_ICFG],
	input  wire rowcnt_t i_cfg0_row_counts  [`DMA_N_ICFG],
	input  wire addr_t   i_cfg0_row_bounds  [`DMA_N_ICFG],
	input  wire data_t   i_cfg0_pad_values  [`DMA_N_ICFG],
	input  wire lane_t   i_cfg0_xor_masks   [`DMA_N_ICFG],
	input  wire addr_t   i_cfg1_linears     [`DMA_N_ICFG],
	input  wire addr_t   i_cfg1_row_strides [`DMA_N_ICFG],
	input  wire rowcnt_t i_cfg1_row_counts  [`DMA_N_ICFG],
	input  wire addr_t   i_cfg1_row_bounds  [`DMA_N_ICFG],
	input  wire data_t   i_cfg1_pad_values  [`DMA_N_ICFG],
	input  wire lane_t   i_cfg1_xor_masks   [`DMA_N_ICFG],
	// Read pipeline requests
	input  wire          i_rp_en0_rdy,
	input  wire          i_rp_en1_rdy,
	output logic         o_rp_en0_ack,
	output logic         o_rp_en1_ack,
	// DRAM
	output logic         o_dramra_rdy,
	input  wire          i_dramra_ack,
	output addr_t        o_dramra,
	input  wire          i_dramrd_rdy,
	output logic         o_dramrd_ack,
	input  wire vec_t    i_dramrd,
	// SRAM write
	output logic         o_rmc_write0_dval,
	output logic         o_rmc_write1_dval,
	output hiaddr_t      o_rmc_whiaddr,
	output vec_t         o_rmc_wdata
);

	logic       cmd_rdy;
	logic       cmd_ack;
	chunk_cmd_t cmd;
	logic       row_rdy;
	logic       row_ack;
	row_cmd_t   row;

	dma_chunk_head u_chunk_head (
		.i_clk, .i_rst_n, .i_bofs_rdy, .o_bofs_ack,
		.i_which, .i_row_ofs, .i_col_ofs, .i_cfg_id,
		.i_cfg0_linears, .i_cfg0_row_strides, .i_cfg0_row_counts,
		.i_cfg0_row_bounds, .i_cfg0_pad_values, .i_cfg0_xor_masks,
		.i_cfg1_linears, .i_cfg1_row_strides, .i_cfg1_row_counts,
		.i_cfg1_row_bounds, .i_cfg1_pad_values, .i_cfg1_xor_masks,
		.i_rp_en0_rdy, .i_rp_en1_rdy, .o_rp_en0_ack, .o_rp_en1_ack,
		.o_cmd_rdy(cmd_rdy),
		.i_cmd_ack(cmd_ack),
		.o_cmd    (cmd)
	);

	dma_row_looper u_row_looper (
		.i_clk, .i_rst_n,
		.i_cmd_rdy(cmd_rdy),
		.o_cmd_ack(cmd_ack),
		.i_cmd    (cmd),
		.o_dramra_rdy, .i_dramra_ack, .o_dramra,
		.o_row_rdy(row_rdy),
		.i_row_ack(row_ack),
		.o_row    (row)
	);

	dma_sram_writer u_sram_writer (
		.i_clk, .i_rst_n,
		.i_row_rdy(row_rdy),
		.o_row_ack(row_ack),
		.i_row    (row),
		.i_dramrd_rdy, .o_dramrd_ack, .i_dramrd,
		.o_rmc_write0_dval, .o_rmc_write1_dval, .o_rmc_whiaddr, .o_rmc_wdata
	);

endmodule

`default_nettype wire

/* testbench/tb_dram_model.sv */
// DRAM responder for the DMA testbench, takes every read address and returns its beat after a random delay
`default_nettype none

`include "dma_defs.svh"

module tb_dram_model
	import dma_cfg_pkg::*;
(
	input  wire        i_clk,
	input  wire        i_rst_n,
	input  wire        i_ra_rdy,
	output logic       o_ra_ack,
	input  wire addr_t i_ra,
	output logic       o_rd_rdy,
	input  wire        i_rd_ack,
	output vec_t       o_rd
);
	timeunit 1ns;
	timeprecision 100ps;

	addr_t       pend_addr [$];
	int          pend_due [$];
	addr_t       head;
	int          cycle;
	logic [31:0] state;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Address side never stalls, the delay sits on the data side
	assign o_ra_ack = i_ra_rdy && i_rst_n;

	initial begin
		state    = 32'd44510;
		cycle    = 0;
		o_rd_rdy = 1'b0;
		o_rd     = '0;
		forever begin
			@(posedge i_clk);
			if (!i_rst_n) begin
				pend_addr.delete();
				pend_due.delete();
			end else begin
				cycle++;
				if (o_rd_rdy && i_rd_ack) begin
					void'(pend_addr.pop_front());
					void'(pend_due.pop_front());
				end
				// Each request waits 0 to 3 extra cycles
				if (o_ra_ack) begin
					state = xorshift32(state);
					pend_addr.push_back(i_ra);
					pend_due.push_back(cycle + int'(state[1:0]));
				end
			end
			#1;
			if (pend_addr.size() != 0 && pend_due[0] <= cycle) begin
				head     = pend_addr[0];
				o_rd_rdy = 1'b1;
				for (int k = 0; k < `DMA_VSIZE; k++) begin
					o_rd[k] = head[7:0] + data_t'(k);
				end
			end else begin
				o_rd_rdy = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* testbench/tb_dma_pipeline.sv */
// Testbench top that runs a command table through the DMA pipeline and checks reads and writes
`default_nettype none

`include "dma_defs.svh"

module tb_dma_pipeline
	import dma_cfg_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_TESTS = 9;
	localparam int TIMEOUT = 40 * N_TESTS + 100;
	localparam int MAX_EXP = 128;

	typedef struct packed {
		addr_t   linear;
		addr_t   stride;
		rowcnt_t count;
		addr_t   bound;
		data_t   pad;
		lane_t   mask;
	} cfg_t;

	typedef struct packed {
		logic       which;
		cfg_id_t    cfg_id;
		addr_t      row_ofs;
		addr_t      col_ofs;
		logic [3:0] hold;
	} test_t;

	typedef struct packed {
		logic [7:0] test;
		logic       which;
		hiaddr_t    hiaddr;
		vec_t       data;
	} write_t;

	logic    clk = 1'b0;
	logic    rst_n;
	logic    bofs_rdy;
	logic    bofs_ack;
	logic    which;
	addr_t   row_ofs;
	addr_t   col_ofs;
	cfg_id_t cfg_id;
	logic    rp_en0_rdy;
	logic    rp_en1_rdy;
	logic    rp_en0_ack;
	logic    rp_en1_ack;
	logic    dramra_rdy;
	logic    dramra_ack;
	addr_t   dramra;
	logic    dramrd_rdy;
	logic    dramrd_ack;
	vec_t    dramrd;
	logic    write0_dval;
	logic    write1_dval;
	hiaddr_t whiaddr;
	vec_t    wdata;

	addr_t   cfg0_linears [`DMA_N_ICFG];
	addr_t   cfg0_row_strides [`DMA_N_ICFG];
	rowcnt_t cfg0_row_counts [`DMA_N_ICFG];
	addr_t   cfg0_row_bounds [`DMA_N_ICFG];
	data_t   cfg0_pad_values [`DMA_N_ICFG];
	lane_t   cfg0_xor_masks [`DMA_N_ICFG];
	addr_t   cfg1_linears [`DMA_N_ICFG];
	addr_t   cfg1_row_strides [`DMA_N_ICFG];
	rowcnt_t cfg1_row_counts [`DMA_N_ICFG];
	addr_t   cfg1_row_bounds [`DMA_N_ICFG];
	data_t   cfg1_pad_values [`DMA_N_ICFG];
	lane_t   cfg1_xor_masks [`DMA_N_ICFG];

	cfg_t       cfgs [2][`DMA_N_ICFG];
	test_t      tests [N_TESTS];
	string      names [N_TESTS];
	write_t     exp_w [MAX_EXP];
	addr_t      exp_addr [MAX_EXP];
	logic [7:0] exp_addr_test [MAX_EXP];
	int         n_exp_w;
	int         n_got_w;
	int         n_exp_a;
	int         n_got_a;
	int         cycles;

	always #4 clk = ~clk;

	// Spread the two tables onto the DUT ports
	always_comb begin
		for (int i = 0; i < `DMA_N_ICFG; i++) begin
			cfg0_linears[i]     = cfgs[0][i].linear;
			cfg0_row_strides[i] = cfgs[0][i].stride;
			cfg0_row_counts[i]  = cfgs[0][i].count;
			cfg0_row_bounds[i]  = cfgs[0][i].bound;
			cfg0_pad_values[i]  = cfgs[0][i].pad;
			cfg0_xor_masks[i]   = cfgs[0][i].mask;
			cfg1_linears[i]     = cfgs[1][i].linear;
			cfg1_row_strides[i] = cfgs[1][i].stride;
			cfg1_row_counts[i]  = cfgs[1][i].count;
			cfg1_row_bounds[i]  = cfgs[1][i].bound;
			cfg1_pad_values[i]  = cfgs[1][i].pad;
			cfg1_xor_masks[i]   = cfgs[1][i].mask;
		end
	end

	dma_pipeline DUT (
		.i_clk(clk), .i_rst_n(rst_n),
		.i_bofs_rdy(bofs_rdy), .o_bofs_ack(bofs_ack),
		.i_which(which), .i_row_ofs(row_ofs), .i_col_ofs(col_ofs), .i_cfg_id(cfg_id),
		.i_cfg0_linears(cfg0_linears), .i_cfg0_row_strides(cfg0_row_strides),
		.i_cfg0_row_counts(cfg0_row_counts), .i_cfg0_row_bounds(cfg0_row_bounds),
		.i_cfg0_pad_values(cfg0_pad_values), .i_cfg0_xor_masks(cfg0_xor_masks),
		.i_cfg1_linears(cfg1_linears), .i_cfg1_row_strides(cfg1_row_strides),
		.i_cfg1_row_counts(cfg1_row_counts), .i_cfg1_row_bounds(cfg1_row_bounds),
		.i_cfg1_pad_values(cfg1_pad_values), .i_cfg1_xor_masks(cfg1_xor_masks),
		.i_rp_en0_rdy(rp_en0_rdy), .i_rp_en1_rdy(rp_en1_rdy),
		.o_rp_en0_ack(rp_en0_ack), .o_rp_en1_ack(rp_en1_ack),
		.o_dramra_rdy(dramra_rdy), .i_dramra_ack(dramra_ack), .o_dramra(dramra),
		.i_dramrd_rdy(dramrd_rdy), .o_dramrd_ack(dramrd_ack), .i_dramrd(dramrd),
		.o_rmc_write0_dval(write0_dval), .o_rmc_write1_dval(write1_dval),
		.o_rmc_whiaddr(whiaddr), .o_rmc_wdata(wdata)
	);

	tb_dram_model u_dram (
		.i_clk(clk), .i_rst_n(rst_n),
		.i_ra_rdy(dramra_rdy), .o_ra_ack(dramra_ack), .i_ra(dramra),
		.o_rd_rdy(dramrd_rdy), .i_rd_ack(dramrd_ack), .o_rd(dramrd)
	);

	// ==============================
	// Checking
	// ==============================
	task automatic fail_run(input string why);
		$display("ERROR: %s", why);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped on an error");
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (expected !== actual) begin
			$display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
			$display("STATUS: FAIL");
			$fatal(1, "simulation stopped on a mismatch");
		end
	endtask

	// Expected reads and writes of one command
	task automatic expect_cmd(input int t);
		cfg_t   c;
		addr_t  base;
		addr_t  addr;
		int     data_rows;
		vec_t   src;
		write_t w;
		c    = cfgs[tests[t].which][tests[t].cfg_id];
		base = c.linear + tests[t].row_ofs * c.stride + tests[t].col_ofs;
		// Rows below the boundary read DRAM and the rest are padding
		if (c.bound > tests[t].row_ofs) data_rows = int'(c.bound - tests[t].row_ofs);
		else data_rows = 0;
		for (int r = 0; r < int'(c.count); r++) begin
			addr = base + addr_t'(r) * c.stride;
			for (int k = 0; k < `DMA_VSIZE; k++) begin
				if (r < data_rows) src[k] = addr[7:0] + data_t'(k);
				else src[k] = c.pad;
			end
			if (r < data_rows) begin
				exp_addr[n_exp_a]      = addr;
				exp_addr_test[n_exp_a] = 8'(t);
				n_exp_a++;
			end
			w.test   = 8'(t);
			w.which  = tests[t].which;
			w.hiaddr = hiaddr_t'(r);
			for (int k = 0; k < `DMA_VSIZE; k++) begin
				w.data[k] = src[lane_t'(k) ^ c.mask];
			end
			exp_w[n_exp_w] = w;
			n_exp_w++;
		end
	endtask

	task automatic send_cmd(input int t);
		logic acked;
		bofs_rdy = 1'b1;
		which    = tests[t].which;
		row_ofs  = tests[t].row_ofs;
		col_ofs  = tests[t].col_ofs;
		cfg_id   = tests[t].cfg_id;
		// Target read pipeline stays idle for a while
		repeat (int'(tests[t].hold)) begin
			@(posedge clk);
			check_value({names[t], " ack while enable low"}, 64'(0), 64'(bofs_ack));
			#1;
		end
		if (tests[t].which) rp_en1_rdy = 1'b1;
		else rp_en0_rdy = 1'b1;
		acked = 1'b0;
		while (!acked) begin
			@(posedge clk);
			acked = bofs_ack;
			if (acked) begin
				check_value({names[t], " enable ack"},
					64'({tests[t].which, !tests[t].which}), 64'({rp_en1_ack, rp_en0_ack}));
			end
			#1;
		end
		bofs_rdy   = 1'b0;
		rp_en0_rdy = 1'b0;
		rp_en1_rdy = 1'b0;
	endtask

	always @(posedge clk) begin
		if (rst_n && dramra_rdy && dramra_ack) begin
			if (n_got_a >= n_exp_a) begin
				fail_run("a DRAM read was issued that no command asked for");
			end else begin
				check_value({names[exp_addr_test[n_got_a]], " dram address"},
					64'(exp_addr[n_got_a]), 64'(dramra));
				n_got_a <= n_got_a + 1;
			end
		end
	end

	always @(posedge clk) begin
		if (rst_n && (write0_dval || write1_dval)) begin
			if (n_got_w >= n_exp_w) begin
				fail_run("an SRAM write arrived when none was expected");
			end else begin
				check_value({names[exp_w[n_got_w].test], " write strobe"},
					64'({exp_w[n_got_w].which, !exp_w[n_got_w].which}),
					64'({write1_dval, write0_dval}));
				check_value({names[exp_w[n_got_w].test], " hiaddr"},
					64'(exp_w[n_got_w].hiaddr), 64'(whiaddr));
				check_value({names[exp_w[n_got_w].test], " data"},
					64'(exp_w[n_got_w].data), 64'(wdata));
				n_got_w <= n_got_w + 1;
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) fail_run("timeout, the command table did not finish in time");
	end

	// ==============================
	// Stimulus
	// ==============================
	initial begin
		rst_n      = 1'b0;
		bofs_rdy   = 1'b0;
		which      = 1'b0;
		row_ofs    = '0;
		col_ofs    = '0;
		cfg_id     = '0;
		rp_en0_rdy = 1'b0;
		rp_en1_rdy = 1'b0;
		// linear, stride, rows, row boundary, pad value, xor mask
		cfgs[0][0] = {16'h0100, 16'h0010, 5'd4, 16'h0040, 8'hA5, 2'd0};
		cfgs[0][1] = {16'h0200, 16'h0008, 5'd4, 16'h0006, 8'h5A, 2'd0};
		cfgs[0][2] = {16'h0300, 16'h0004, 5'd3, 16'h0040, 8'h11, 2'd3};
		cfgs[0][3] = {16'h0400, 16'h0020, 5'd3, 16'h0002, 8'hEE, 2'd1};
		cfgs[1][0] = {16'h1000, 16'h0010, 5'd3, 16'h0020, 8'h33, 2'd2};
		cfgs[1][1] = {16'h1100, 16'h0004, 5'd4, 16'h0003, 8'h77, 2'd1};
		cfgs[1][2] = {16'h1200, 16'h0002, 5'd6, 16'h0100, 8'h00, 2'd0};
		cfgs[1][3] = {16'h1340, 16'h0001, 5'd5, 16'h0010, 8'h44, 2'd3};
		// which, cfg id, row offset, col offset, enable hold cycles
		tests[0] = {1'b0, 2'd0, 16'd2, 16'd3, 4'd0};
		names[0] = "buf0_inside";
		tests[1] = {1'b0, 2'd1, 16'd4, 16'd0, 4'd0};
		names[1] = "buf0_pad";
		tests[2] = {1'b0, 2'd2, 16'd1, 16'd2, 4'd0};
		names[2] = "buf0_xor";
		tests[3] = {1'b0, 2'd3, 16'd3, 16'd0, 4'd0};
		names[3] = "buf0_all_pad";
		tests[4] = {1'b1, 2'd0, 16'd0, 16'd5, 4'd0};
		names[4] = "buf1_table";
		tests[5] = {1'b1, 2'd1, 16'd1, 16'd0, 4'd0};
		names[5] = "buf1_pad_xor";
		tests[6] = {1'b0, 2'd0, 16'd0, 16'd0, 4'd12};
		names[6] = "buf0_hold";
		tests[7] = {1'b1, 2'd3, 16'd2, 16'd1, 4'd8};
		names[7] = "buf1_hold";
		tests[8] = {1'b1, 2'd2, 16'd0, 16'd0, 4'd0};
		names[8] = "buf1_long";
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		for (int t = 0; t < N_TESTS; t++) begin
			expect_cmd(t);
			send_cmd(t);
		end
		while (n_got_w != n_exp_w) @(posedge clk);
		repeat (8) @(posedge clk);
		check_value("end dram read count", 64'(n_exp_a), 64'(n_got_a));
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
hdl/dma_cfg_pkg.sv
hdl/dma_cmd_pkg.sv
hdl/dma_queue.sv
hdl/dma_chunk_head.sv
hdl/dma_row_looper.sv
hdl/dma_sram_writer.sv
hdl/dma_pipeline.sv
testbench/tb_dram_model.sv
testbench/tb_dma_pipeline.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dma_pipeline
BUILD_DIR ?= obj_dir
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

SOURCES := dma_defs.svh $(wildcard hdl/*.sv) $(wildcard testbench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
